// ==== logic/mem_stage_macros.svh ====
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Data path and address width
`define WORD_W 32

// Pending stores held in the store buffer
`define SB_DEPTH 4

// Direct-mapped cache lines, one word each
`define CACHE_LINES 8

// Words in the backing array
// Byte addresses wrap modulo 4*MEM_WORDS
`define MEM_WORDS 64

`endif

// ==== logic/isa_pkg.sv ====
package isa_pkg;

    // Major opcodes handled by the memory stage
    typedef enum logic [6:0] {
        LOAD  = 7'b0000011,
        STORE = 7'b0100011,
        OP    = 7'b0110011
    } opcode_e;

    // Encoded to match funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } access_size_e;

    // I-type layout, used by loads
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } instr_i_t;

    // S-type layout, immediate split around rs2
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        opcode_e     opcode;
    } instr_s_t;

    // One instruction word seen through either layout
    typedef union packed {
        instr_i_t i_fmt;
        instr_s_t s_fmt;
    } instr_u;

endpackage

// ==== logic/mem_pkg.sv ====
`include "mem_stage_macros.svh"

package mem_pkg;

    // One pending store
    // Data is already placed in its byte lanes
    typedef struct packed {
        logic [`WORD_W-3:0] word_addr;
        logic [`WORD_W-1:0] data;
        logic [3:0]         be;
    } sb_entry_t;

    // Store buffer drain control
    typedef enum logic {
        NORMAL   = 1'b0,
        DRAINING = 1'b1
    } drain_state_e;

endpackage

// ==== logic/memop_decode.sv ====
`include "mem_stage_macros.svh"

module memop_decode
    import isa_pkg::*;
(
    input  logic               valid_i,
    input  instr_u             instr_i,
    input  logic [`WORD_W-1:0] rs1_val_i,
    input  logic [`WORD_W-1:0] rs2_val_i,
    output logic               is_load_o,
    output logic               is_store_o,
    output logic               is_alu_o,
    output logic [`WORD_W-1:0] addr_o,
    output access_size_e       size_o,
    output logic               sign_ext_o,
    output logic [`WORD_W-1:0] store_data_o
);

    logic [`WORD_W-1:0] imm;
    logic [2:0]         funct3;

    // Opcode and funct3 share their bits in both layouts
    assign is_load_o  = valid_i && (instr_i.i_fmt.opcode == LOAD);
    assign is_store_o = valid_i && (instr_i.s_fmt.opcode == STORE);
    assign is_alu_o   = valid_i && (instr_i.i_fmt.opcode == OP);
    assign funct3     = instr_i.i_fmt.funct3;

    // Stores take the split S immediate, everything else the I immediate
    always_comb begin
        if (instr_i.s_fmt.opcode == STORE) begin
            imm = {{(`WORD_W-12){instr_i.s_fmt.imm_hi[6]}},
                   instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
        end else begin
            imm = {{(`WORD_W-12){instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
        end
    end

    // Effective address
    assign addr_o = rs1_val_i + imm;

    // Low funct3 bits give the size
    always_comb begin
        case (funct3[1:0])
            2'b00:   size_o = BYTE;
            2'b01:   size_o = HALF;
            default: size_o = WORD;
        endcase
    end

    // LBU and LHU set funct3[2]
    assign sign_ext_o = !funct3[2];

    // Replicate store data so every lane holds a copy
    always_comb begin
        case (size_o)
            BYTE:    store_data_o = {4{rs2_val_i[7:0]}};
            HALF:    store_data_o = {2{rs2_val_i[15:0]}};
            default: store_data_o = rs2_val_i;
        endcase
    end

endmodule

// ==== logic/store_buffer.sv ====
`include "mem_stage_macros.svh"

module store_buffer
    import isa_pkg::*;
    import mem_pkg::*;
(
    input  logic               clk_i,
    input  logic               rsn_i,
    input  logic               is_load_i,
    input  logic               is_store_i,
    input  logic               is_alu_i,
    input  logic               accept_i,
    input  logic [`WORD_W-1:0] addr_i,
    input  access_size_e       size_i,
    input  logic [`WORD_W-1:0] store_data_i,
    input  logic               cache_hit_i,
    output logic               wr_en_o,
    output logic [`WORD_W-1:0] wr_addr_o,
    output logic [`WORD_W-1:0] wr_data_o,
    output logic [3:0]         wr_be_o,
    output logic               fwd_hit_o,
    output logic [`WORD_W-1:0] fwd_data_o,
    output logic [3:0]         fwd_be_o,
    output logic               draining_o,
    output logic               full_o
);

    localparam int PTR_W = $clog2(`SB_DEPTH);

    sb_entry_t            entries [`SB_DEPTH];
    logic [`SB_DEPTH-1:0] valid_q;
    logic [PTR_W-1:0]     rd_ptr_q;
    logic [PTR_W-1:0]     wr_ptr_q;
    drain_state_e         state_q;
    drain_state_e         state_d;
    logic                 empty;
    logic [`SB_DEPTH-1:0] match;
    logic                 any_match;
    logic                 load_conflict;
    logic                 push;
    logic [3:0]           new_be;

    assign full_o = &valid_q;
    assign empty  = ~|valid_q;

    // Full word address compare against every live entry
    always_comb begin
        for (int i = 0; i < `SB_DEPTH; i++) begin
            match[i] = valid_q[i] && (entries[i].word_addr == addr_i[`WORD_W-1:2]);
        end
    end
    assign any_match = |match;

    // Load that misses while its word is still buffered
    assign load_conflict = is_load_i && !cache_hit_i && any_match;

    // Walk oldest to youngest so younger bytes overwrite older ones
    always_comb begin : fwd_merge
        logic [PTR_W-1:0] idx;
        fwd_data_o = '0;
        fwd_be_o   = '0;
        for (int k = 0; k < `SB_DEPTH; k++) begin
            idx = rd_ptr_q + PTR_W'(k);
            if (match[idx]) begin
                for (int b = 0; b < 4; b++) begin
                    if (entries[idx].be[b]) begin
                        fwd_data_o[8*b +: 8] = entries[idx].data[8*b +: 8];
                    end
                end
                fwd_be_o = fwd_be_o | entries[idx].be;
            end
        end
    end
    assign fwd_hit_o = is_load_i && any_match && (state_q == NORMAL);

    // Drain FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            NORMAL: begin
                if ((is_store_i && full_o) || load_conflict) begin
                    state_d = DRAINING;
                end
            end
            DRAINING: begin
                if (empty) begin
                    state_d = NORMAL;
                end
            end
            default: state_d = NORMAL;
        endcase
    end

    // Stall request, full stores are handled at the top level
    assign draining_o = (state_q == DRAINING) || load_conflict;

    // Oldest entry goes out on a free port or while draining
    assign wr_en_o   = !empty && ((state_q == DRAINING) || (accept_i && is_alu_i));
    assign wr_addr_o = {entries[rd_ptr_q].word_addr, 2'b00};
    assign wr_data_o = entries[rd_ptr_q].data;
    assign wr_be_o   = entries[rd_ptr_q].be;

    // Accept already excludes a full buffer
    assign push = accept_i && is_store_i;

    // Byte enables from size and offset
    always_comb begin
        case (size_i)
            BYTE:    new_be = 4'b0001 << addr_i[1:0];
            HALF:    new_be = 4'b0011 << {addr_i[1], 1'b0};
            default: new_be = 4'b1111;
        endcase
    end

    always_ff @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            state_q  <= NORMAL;
            valid_q  <= '0;
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
        end else begin
            state_q <= state_d;
            if (push) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= wr_ptr_q + 1'b1;
            end
            if (wr_en_o) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (push) begin
            entries[wr_ptr_q] <= '{word_addr: addr_i[`WORD_W-1:2],
                                   data:      store_data_i,
                                   be:        new_be};
        end
    end

endmodule

// ==== logic/data_cache.sv ====
`include "mem_stage_macros.svh"

module data_cache (
    input  logic               clk_i,
    input  logic               rsn_i,
    input  logic               rd_en_i,
    input  logic [`WORD_W-1:0] rd_addr_i,
    input  logic               wr_en_i,
    input  logic [`WORD_W-1:0] wr_addr_i,
    input  logic [`WORD_W-1:0] wr_data_i,
    input  logic [3:0]         wr_be_i,
    output logic [`WORD_W-1:0] rd_data_o,
    output logic               cache_hit_o,
    output logic               fill_busy_o
);

    localparam int IDX_W  = $clog2(`CACHE_LINES);
    localparam int MEM_AW = $clog2(`MEM_WORDS);
    localparam int TAG_W  = MEM_AW - IDX_W;

    // Backing store and line arrays
    logic [`WORD_W-1:0]      mem [`MEM_WORDS];
    logic [`WORD_W-1:0]      line_data [`CACHE_LINES];
    logic [TAG_W-1:0]        line_tag [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] line_valid;

    logic [MEM_AW-1:0] rd_word;
    logic [MEM_AW-1:0] wr_word;
    logic [IDX_W-1:0]  rd_idx;
    logic [IDX_W-1:0]  wr_idx;
    logic              wr_line_hit;

    // Upper address bits wrap into the backing array
    assign rd_word = rd_addr_i[MEM_AW+1:2];
    assign wr_word = wr_addr_i[MEM_AW+1:2];
    assign rd_idx  = rd_word[IDX_W-1:0];
    assign wr_idx  = wr_word[IDX_W-1:0];

    // Lookup does not depend on rd_en_i
    assign cache_hit_o = line_valid[rd_idx] && (line_tag[rd_idx] == rd_word[MEM_AW-1:IDX_W]);
    assign rd_data_o   = line_data[rd_idx];

    // One stall cycle per miss
    assign fill_busy_o = rd_en_i && !cache_hit_o;

    // Write-through only updates a resident line
    assign wr_line_hit = line_valid[wr_idx] && (line_tag[wr_idx] == wr_word[MEM_AW-1:IDX_W]);

    always_ff @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            line_valid <= '0;
        end else if (fill_busy_o) begin
            line_valid[rd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        // Miss fill from the backing word
        if (fill_busy_o) begin
            line_data[rd_idx] <= mem[rd_word];
            line_tag[rd_idx]  <= rd_word[MEM_AW-1:IDX_W];
        end
        // Byte-enabled write to memory and matching line
        if (wr_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be_i[b]) begin
                    mem[wr_word][8*b +: 8] <= wr_data_i[8*b +: 8];
                    if (wr_line_hit) begin
                        line_data[wr_idx][8*b +: 8] <= wr_data_i[8*b +: 8];
                    end
                end
            end
        end
    end

endmodule

// ==== logic/load_result.sv ====
`include "mem_stage_macros.svh"

module load_result
    import isa_pkg::*;
(
    input  logic               clk_i,
    input  logic               rsn_i,
    input  logic               load_fire_i,
    input  logic [1:0]         addr_i,
    input  access_size_e       size_i,
    input  logic               sign_ext_i,
    input  logic [`WORD_W-1:0] cache_data_i,
    input  logic               fwd_hit_i,
    input  logic [`WORD_W-1:0] fwd_data_i,
    input  logic [3:0]         fwd_be_i,
    output logic               result_valid_o,
    output logic [`WORD_W-1:0] result_o
);

    logic [`WORD_W-1:0] merged;
    logic [`WORD_W-1:0] shifted;
    logic [`WORD_W-1:0] extended;

    // Buffered bytes win over the cache word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = (fwd_hit_i && fwd_be_i[b]) ? fwd_data_i[8*b +: 8]
                                                          : cache_data_i[8*b +: 8];
        end
    end

    // Bring the addressed byte to lane 0
    assign shifted = merged >> {addr_i, 3'b000};

    always_comb begin
        case (size_i)
            BYTE:    extended = {{(`WORD_W-8){sign_ext_i && shifted[7]}}, shifted[7:0]};
            HALF:    extended = {{(`WORD_W-16){sign_ext_i && shifted[15]}}, shifted[15:0]};
            default: extended = shifted;
        endcase
    end

    // Valid pulse one cycle after acceptance
    always_ff @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= load_fire_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_fire_i) begin
            result_o <= extended;
        end
    end

endmodule

// ==== logic/mem_stage_top.sv ====
`include "mem_stage_macros.svh"

module mem_stage_top
    import isa_pkg::*;
(
    input  logic               clk_i,
    input  logic               rsn_i,
    input  logic               valid_i,
    input  instr_u             instr_i,
    input  logic [`WORD_W-1:0] rs1_val_i,
    input  logic [`WORD_W-1:0] rs2_val_i,
    output logic               stall_o,
    output logic               result_valid_o,
    output logic [`WORD_W-1:0] result_o
);

    // Decoded operation
    logic               dec_is_load;
    logic               dec_is_store;
    logic               dec_is_alu;
    logic [`WORD_W-1:0] dec_addr;
    access_size_e       dec_size;
    logic               dec_sign_ext;
    logic [`WORD_W-1:0] dec_store_data;

    // Buffer drain port and forwarding
    logic               sb_wr_en;
    logic [`WORD_W-1:0] sb_wr_addr;
    logic [`WORD_W-1:0] sb_wr_data;
    logic [3:0]         sb_wr_be;
    logic               fwd_hit;
    logic [`WORD_W-1:0] fwd_data;
    logic [3:0]         fwd_be;
    logic               sb_draining;
    logic               sb_full;

    // Cache side
    logic               cache_rd_en;
    logic [`WORD_W-1:0] cache_rd_data;
    logic               cache_hit;
    logic               fill_busy;

    logic               accept;
    logic               load_fire;

    // Stall on drain, on a store into a full buffer, or on a miss fill
    assign stall_o   = sb_draining || (dec_is_store && sb_full) || fill_busy;
    assign accept    = valid_i && !stall_o;
    assign load_fire = accept && dec_is_load;

    // Hold the fill off until a conflicting drain has finished
    assign cache_rd_en = dec_is_load && !sb_draining;

    memop_decode u_decode (
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .rs1_val_i    (rs1_val_i),
        .rs2_val_i    (rs2_val_i),
        .is_load_o    (dec_is_load),
        .is_store_o   (dec_is_store),
        .is_alu_o     (dec_is_alu),
        .addr_o       (dec_addr),
        .size_o       (dec_size),
        .sign_ext_o   (dec_sign_ext),
        .store_data_o (dec_store_data)
    );

    store_buffer u_sb (
        .clk_i        (clk_i),
        .rsn_i        (rsn_i),
        .is_load_i    (dec_is_load),
        .is_store_i   (dec_is_store),
        .is_alu_i     (dec_is_alu),
        .accept_i     (accept),
        .addr_i       (dec_addr),
        .size_i       (dec_size),
        .store_data_i (dec_store_data),
        .cache_hit_i  (cache_hit),
        .wr_en_o      (sb_wr_en),
        .wr_addr_o    (sb_wr_addr),
        .wr_data_o    (sb_wr_data),
        .wr_be_o      (sb_wr_be),
        .fwd_hit_o    (fwd_hit),
        .fwd_data_o   (fwd_data),
        .fwd_be_o     (fwd_be),
        .draining_o   (sb_draining),
        .full_o       (sb_full)
    );

    data_cache u_cache (
        .clk_i       (clk_i),
        .rsn_i       (rsn_i),
        .rd_en_i     (cache_rd_en),
        .rd_addr_i   (dec_addr),
        .wr_en_i     (sb_wr_en),
        .wr_addr_i   (sb_wr_addr),
        .wr_data_i   (sb_wr_data),
        .wr_be_i     (sb_wr_be),
        .rd_data_o   (cache_rd_data),
        .cache_hit_o (cache_hit),
        .fill_busy_o (fill_busy)
    );

    load_result u_result (
        .clk_i          (clk_i),
        .rsn_i          (rsn_i),
        .load_fire_i    (load_fire),
        .addr_i         (dec_addr[1:0]),
        .size_i         (dec_size),
        .sign_ext_i     (dec_sign_ext),
        .cache_data_i   (cache_rd_data),
        .fwd_hit_i      (fwd_hit),
        .fwd_data_i     (fwd_data),
        .fwd_be_i       (fwd_be),
        .result_valid_o (result_valid_o),
        .result_o       (result_o)
    );

endmodule

// ==== testbench/mem_stage_checker.sv ====
`include "mem_stage_macros.svh"

module mem_stage_checker
    import mem_pkg::*;
(
    input logic                         clk_i,
    input logic                         rsn_i,
    input logic                         wr_en_i,
    input logic [`SB_DEPTH-1:0]         valid_q_i,
    input logic [$clog2(`SB_DEPTH)-1:0] rd_ptr_i,
    input logic                         full_i,
    input logic                         accept_i,
    input logic                         is_store_i,
    input drain_state_e                 state_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // Edges already spent in DRAINING
    int drain_cycles;

    // Failed assertions so far, watched from the testbench
    int unsigned assert_failures = 0;

    always_ff @(posedge clk_i or negedge rsn_i) begin
        if (!rsn_i) begin
            drain_cycles <= 0;
        end else if (state_i == DRAINING) begin
            drain_cycles <= drain_cycles + 1;
        end else begin
            drain_cycles <= 0;
        end
    end

    // Drain port only fires from a live oldest slot
    write_needs_entry: assert property (@(posedge clk_i) disable iff (!rsn_i)
        wr_en_i |-> valid_q_i[rd_ptr_i])
        else begin
            assert_failures++;
            $error("store buffer wrote to memory from an empty slot");
        end

    // Stall must hold off a store into a full buffer
    no_push_when_full: assert property (@(posedge clk_i) disable iff (!rsn_i)
        !(full_i && accept_i && is_store_i))
        else begin
            assert_failures++;
            $error("store accepted into a full buffer");
        end

    // A full drain takes one edge per entry plus the return edge
    drain_bounded: assert property (@(posedge clk_i) disable iff (!rsn_i)
        (state_i == DRAINING) |-> (drain_cycles < `SB_DEPTH + 1))
        else begin
            assert_failures++;
            $error("store buffer stayed in DRAINING too long");
        end

endmodule

bind store_buffer mem_stage_checker u_checker (
    .clk_i      (clk_i),
    .rsn_i      (rsn_i),
    .wr_en_i    (wr_en_o),
    .valid_q_i  (valid_q),
    .rd_ptr_i   (rd_ptr_q),
    .full_i     (full_o),
    .accept_i   (accept_i),
    .is_store_i (is_store_i),
    .state_i    (state_q)
);

// ==== testbench/tb_mem_stage.sv ====
`include "mem_stage_macros.svh"

module tb_mem_stage
    import isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_INIT   = 16;
    localparam int NUM_RANDOM = 600;
    // Worst case per instruction is a full drain plus accept, with slack for reset
    localparam int TIMEOUT_CYCLES = (NUM_INIT + NUM_RANDOM) * (`SB_DEPTH + 3) + 16;
    localparam int KIND_LOAD  = 0;
    localparam int KIND_STORE = 1;
    localparam int KIND_ALU   = 2;

    logic               clk;
    logic               rsn;
    logic               valid;
    instr_u             instr;
    logic [`WORD_W-1:0] rs1_val;
    logic [`WORD_W-1:0] rs2_val;
    logic               stall;
    logic               result_valid;
    logic [`WORD_W-1:0] result;

    logic [31:0] lcg_state;
    logic [31:0] model_mem [`MEM_WORDS];
    logic [31:0] expect_q [$];
    logic        pulse_expected;
    int          cycle_count;
    int          store_stalls;
    int          load_stalls;

    mem_stage_top dut (
        .clk_i          (clk),
        .rsn_i          (rsn),
        .valid_i        (valid),
        .instr_i        (instr),
        .rs1_val_i      (rs1_val),
        .rs2_val_i      (rs2_val),
        .stall_o        (stall),
        .result_valid_o (result_valid),
        .result_o       (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run length guard
    initial begin
        cycle_count = 0;
        while (cycle_count <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper LCG bits are the better mixed ones
    function automatic int rand_below(input int limit);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % limit;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    // Architectural view: bytes picked out of the word, then extended per funct3
    function automatic logic [31:0] model_load(input logic [7:0] addr, input logic [2:0] f3);
        logic [31:0] word;
        logic [7:0]  lo;
        logic [7:0]  hi;
        word = model_mem[addr[7:2]];
        lo   = word[{addr[1:0], 3'b000} +: 8];
        hi   = word[{addr[1], 4'b1000} +: 8];
        case (f3)
            3'b000:  return {{24{lo[7]}}, lo};
            3'b100:  return {24'b0, lo};
            3'b001:  return {{16{hi[7]}}, hi, word[{addr[1], 4'b0000} +: 8]};
            3'b101:  return {16'b0, hi, word[{addr[1], 4'b0000} +: 8]};
            default: return word;
        endcase
    endfunction

    task automatic model_store(input logic [7:0] addr, input logic [2:0] f3,
                               input logic [31:0] data);
        case (f3[1:0])
            2'b00:   model_mem[addr[7:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
            2'b01:   model_mem[addr[7:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
            default: model_mem[addr[7:2]] = data;
        endcase
    endtask

    // Loads use the I layout, base register x1 holds zero
    function automatic instr_u make_load(input logic [7:0] addr, input logic [2:0] f3);
        instr_u w;
        w.i_fmt.imm    = {4'b0, addr};
        w.i_fmt.rs1    = 5'd1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd     = 5'd2;
        w.i_fmt.opcode = LOAD;
        return w;
    endfunction

    // Stores split the immediate around rs2
    function automatic instr_u make_store(input logic [7:0] addr, input logic [2:0] f3);
        instr_u w;
        w.s_fmt.imm_hi = {4'b0, addr[7:5]};
        w.s_fmt.rs2    = 5'd3;
        w.s_fmt.rs1    = 5'd1;
        w.s_fmt.funct3 = f3;
        w.s_fmt.imm_lo = addr[4:0];
        w.s_fmt.opcode = STORE;
        return w;
    endfunction

    // Result slot checked at the falling edge, acceptance taken from stable inputs
    task automatic run_cycle(output logic accepted);
        logic [31:0] head;
        @(negedge clk);
        if (dut.u_sb.u_checker.assert_failures != 0) begin
            $display("Error: a store buffer assertion failed at %0d ns", $time);
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failure");
        end
        check_value("result_valid_o", {31'b0, result_valid}, {31'b0, pulse_expected});
        if (pulse_expected) begin
            head = expect_q.pop_front();
            check_value("result_o", result, head);
        end
        accepted       = valid && !stall;
        pulse_expected = accepted && (instr.i_fmt.opcode == LOAD);
        @(posedge clk);
        #1;
    endtask

    // Hold one instruction until accepted, then update the model in program order
    task automatic issue(input int kind, input logic [7:0] addr, input logic [2:0] f3,
                         input logic [31:0] data);
        logic        accepted;
        logic [31:0] noise;
        if (kind == KIND_LOAD) begin
            instr = make_load(addr, f3);
        end else if (kind == KIND_STORE) begin
            instr = make_store(addr, f3);
        end else begin
            noise              = lcg_next();
            instr              = noise;
            instr.i_fmt.opcode = OP;
        end
        valid    = 1'b1;
        rs1_val  = '0;
        rs2_val  = data;
        accepted = 1'b0;
        while (!accepted) begin
            run_cycle(accepted);
            if (!accepted && kind == KIND_STORE) begin
                store_stalls++;
            end
            if (!accepted && kind == KIND_LOAD) begin
                load_stalls++;
            end
        end
        if (kind == KIND_STORE) begin
            model_store(addr, f3, data);
        end else if (kind == KIND_LOAD) begin
            expect_q.push_back(model_load(addr, f3));
        end
        valid = 1'b0;
    endtask

    initial begin
        int          kind;
        int          pick;
        int          word_idx;
        int          off;
        logic [1:0]  sz;
        logic        uns;
        logic [2:0]  f3;
        logic        accepted;
        lcg_state      = 32'h3ed4;
        rsn            = 1'b0;
        valid          = 1'b0;
        instr          = '0;
        rs1_val        = '0;
        rs2_val        = '0;
        pulse_expected = 1'b0;
        store_stalls   = 0;
        load_stalls    = 0;
        for (int i = 0; i < `MEM_WORDS; i++) begin
            model_mem[i] = '0;
        end

        repeat (4) @(posedge clk);
        #1;
        rsn = 1'b1;
        @(negedge clk);
        check_value("stall_o", {31'b0, stall}, 32'd0);
        check_value("result_valid_o", {31'b0, result_valid}, 32'd0);
        @(posedge clk);
        #1;

        // Back-to-back word stores define the 16 test words and overfill the buffer
        for (int w = 0; w < NUM_INIT; w++) begin
            issue(KIND_STORE, 8'(w * 4), 3'b010, lcg_next());
        end

        // Random 4:4:2 mix of loads, stores and ALU ops over 16 words
        for (int n = 0; n < NUM_RANDOM; n++) begin
            pick     = rand_below(10);
            kind     = (pick < 4) ? KIND_LOAD : ((pick < 8) ? KIND_STORE : KIND_ALU);
            sz       = 2'(rand_below(3));
            uns      = (kind == KIND_LOAD) && (sz != 2'b10) && (rand_below(2) == 1);
            word_idx = rand_below(16);
            // Offsets stay aligned to the access size
            if (sz == 2'b00) begin
                off = rand_below(4);
            end else if (sz == 2'b01) begin
                off = 2 * rand_below(2);
            end else begin
                off = 0;
            end
            f3 = {uns, sz};
            issue(kind, 8'(word_idx * 4 + off), f3, lcg_next());
        end

        // Let the last result pulse land
        run_cycle(accepted);
        run_cycle(accepted);

        if (expect_q.size() != 0) begin
            $display("Error: %0d load results never arrived", expect_q.size());
            $display("TEST RESULT: FAIL");
            $fatal(1, "missing load results");
        end else if (store_stalls == 0 || load_stalls == 0) begin
            $display("Error: stall_o never held back a store or a load");
            $display("TEST RESULT: FAIL");
            $fatal(1, "stall paths not exercised");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+logic
logic/isa_pkg.sv
logic/mem_pkg.sv
logic/memop_decode.sv
logic/store_buffer.sv
logic/data_cache.sv
logic/load_result.sv
logic/mem_stage_top.sv
testbench/mem_stage_checker.sv
testbench/tb_mem_stage.sv

// ==== Makefile ====
# Verilator build and run for the memory stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_mem_stage
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
